// File: sim.f
src/spin_rx_pkg.sv
src/step_counter.sv
src/rx_config_regs.sv
src/spin_buffer.sv
src/analog_rx.sv
src/spin_rx_top.sv
testbench/spin_rx_assertions.sv
testbench/tb_spin_rx_top.sv

// File: Bender.yml
package:
  name: spin_rx

sources:
  - src/spin_rx_pkg.sv
  - src/step_counter.sv
  - src/rx_config_regs.sv
  - src/spin_buffer.sv
  - src/analog_rx.sv
  - src/spin_rx_top.sv
  - target: simulation
    files:
      - testbench/spin_rx_assertions.sv
      - testbench/tb_spin_rx_top.sv

// File: testbench/tb_spin_rx_top.sv
`timescale 1ns/1ps
// Table-driven testbench for spin_rx_top with a simple macro idle model
// Every row keeps cyc_cmpt >= cyc_write and a nonzero strobe mask

module tb_spin_rx_top;
    import spin_rx_pkg::*;

    localparam int unsigned NUM_ROWS    = 8;
    localparam int unsigned CYCLE_LIMIT = NUM_ROWS * 60 + 200;

    logic      clk_i;
    logic      reset_i     = 1'b1;
    logic      en_i        = 1'b1;
    logic      cfg_write_i = 1'b0;
    cfg_addr_e cfg_addr_i  = CFG_WWL_STROBE;
    cfg_data_t cfg_wdata_i = '0;
    logic      push_i      = 1'b0;
    spin_vec_t push_spin_i = '0;
    logic      macro_idle_i = 1'b1;
    cfg_data_t cfg_rdata_o;
    logic      cfg_err_o;
    logic      full_o;
    spin_vec_t wbl_o;
    spin_vec_t wwl_o;
    spin_vec_t compute_en_o;
    logic      cmpt_finish_o;
    logic      rx_idle_o;

    // Stimulus table with one row per vector
    spin_vec_t  spin_tab   [NUM_ROWS];
    spin_vec_t  strobe_tab [NUM_ROWS];
    spin_vec_t  mode_tab   [NUM_ROWS];
    cycle_cnt_t wcyc_tab   [NUM_ROWS];
    cycle_cnt_t ccyc_tab   [NUM_ROWS];

    int unsigned errors    = 0;
    int unsigned cycle_cnt = 0;
    int unsigned fin_cnt   = 0;
    logic        have_prev = 1'b0;
    logic        idle_seen = 1'b0;

    spin_rx_top #(
        .BUF_DEPTH (4)
    ) u_spin_rx_top (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .en_i          (en_i),
        .cfg_write_i   (cfg_write_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_wdata_i   (cfg_wdata_i),
        .cfg_rdata_o   (cfg_rdata_o),
        .cfg_err_o     (cfg_err_o),
        .push_i        (push_i),
        .push_spin_i   (push_spin_i),
        .full_o        (full_o),
        .macro_idle_i  (macro_idle_i),
        .wbl_o         (wbl_o),
        .wwl_o         (wwl_o),
        .compute_en_o  (compute_en_o),
        .cmpt_finish_o (cmpt_finish_o),
        .rx_idle_o     (rx_idle_o)
    );

    bind analog_rx spin_rx_assertions u_spin_rx_assertions (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .wwl_o         (wwl_o),
        .rx_idle_o     (rx_idle_o),
        .cmpt_finish_o (cmpt_finish_o),
        .pop_ready_o   (pop_ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Macro goes busy on word lines and reports idle 2 cycles after finish
    always @(posedge clk_i) begin
        if (reset_i) begin
            macro_idle_i <= 1'b1;
            fin_cnt      <= 0;
        end else if (wwl_o != '0) begin
            macro_idle_i <= 1'b0;
            fin_cnt      <= 0;
        end else if (cmpt_finish_o && !macro_idle_i) begin
            if (fin_cnt == 1) begin
                macro_idle_i <= 1'b1;
            end else begin
                fin_cnt <= fin_cnt + 1;
            end
        end
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    task automatic write_cfg(input cfg_addr_e addr, input cfg_data_t data,
                             input cfg_data_t exp);
        @(posedge clk_i);
        cfg_write_i <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk_i);
        cfg_write_i <= 1'b0;
        @(negedge clk_i);
        if (cfg_rdata_o !== exp) begin
            flag_error($sformatf("readback %s got %h expected %h", addr.name(),
                                 cfg_rdata_o, exp));
        end
        if (cfg_err_o !== 1'b0) begin
            flag_error("cfg_err_o set on an idle write");
        end
    endtask

    task automatic load_cfg(input spin_vec_t strobe, input spin_vec_t mode,
                            input cycle_cnt_t w, input cycle_cnt_t c);
        write_cfg(CFG_WWL_STROBE, strobe, strobe);
        write_cfg(CFG_SPIN_MODE, mode, mode);
        // Upper byte must be ignored and read back as zero
        write_cfg(CFG_CYC_WRITE, {8'hA5, w}, {8'h00, w});
        write_cfg(CFG_CYC_CMPT, {8'h5A, c}, {8'h00, c});
    endtask

    task automatic push_vector(input spin_vec_t v);
        @(posedge clk_i);
        push_i      <= 1'b1;
        push_spin_i <= v;
        @(posedge clk_i);
        push_i      <= 1'b0;
    endtask

    // Follows one vector from handshake to finish
    // idx counts cycles after the handshake
    task automatic check_vector(input spin_vec_t spin, input spin_vec_t strobe,
                                input spin_vec_t mode, input cycle_cnt_t w,
                                input cycle_cnt_t c);
        int unsigned idx;
        idx = 0;
        @(negedge clk_i);
        while (wwl_o == '0) begin
            if (macro_idle_i) begin
                idle_seen = 1'b1;
            end
            if (have_prev && !cmpt_finish_o) begin
                flag_error("finish dropped before the next vector");
            end
            @(negedge clk_i);
        end
        if (have_prev && !idle_seen) begin
            flag_error("vector taken before macro_idle_i");
        end
        while (wwl_o != '0) begin
            if (wwl_o !== strobe || compute_en_o !== mode || wbl_o !== spin) begin
                flag_error($sformatf("wbl %h wwl %h cen %h expected %h %h %h",
                                     wbl_o, wwl_o, compute_en_o, spin, strobe, mode));
            end
            if (rx_idle_o !== 1'b0) begin
                flag_error("rx_idle_o high while word lines are up");
            end
            idx++;
            @(negedge clk_i);
        end
        if (idx != w) begin
            flag_error($sformatf("word lines high %0d cycles, expected %0d", idx, w));
        end
        if (compute_en_o !== '0) begin
            flag_error("compute enables left high after word lines");
        end
        if (rx_idle_o !== 1'b1) begin
            flag_error("rx_idle_o still low after word lines fell");
        end
        while (!cmpt_finish_o) begin
            idx++;
            @(negedge clk_i);
        end
        if (idx != c + 1) begin
            flag_error($sformatf("finish after %0d cycles, expected %0d", idx, c + 1));
        end
        if (wbl_o !== spin) begin
            flag_error("bit lines lost the vector before finish");
        end
        have_prev = 1'b1;
        idle_seen = 1'b0;
    endtask

    initial begin
        spin_vec_t burst [5];
        cfg_data_t old_mode;
        int        i;
        void'($urandom(86));
        for (i = 0; i < NUM_ROWS; i++) begin
            spin_tab[i]   = spin_vec_t'($urandom);
            strobe_tab[i] = spin_vec_t'($urandom) | 16'h0001;
            mode_tab[i]   = spin_vec_t'($urandom);
            wcyc_tab[i]   = cycle_cnt_t'(1 + $urandom % 8);
            ccyc_tab[i]   = wcyc_tab[i] + cycle_cnt_t'($urandom % (21 - wcyc_tab[i]));
        end
        // Shortest legal timing
        wcyc_tab[0] = 1;
        ccyc_tab[0] = 1;
        for (i = 0; i < 5; i++) begin
            burst[i] = spin_vec_t'($urandom);
        end

        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;

        for (i = 0; i < NUM_ROWS; i++) begin
            load_cfg(strobe_tab[i], mode_tab[i], wcyc_tab[i], ccyc_tab[i]);
            push_vector(spin_tab[i]);
            check_vector(spin_tab[i], strobe_tab[i], mode_tab[i], wcyc_tab[i],
                         ccyc_tab[i]);
        end

        // Write while the word lines are up
        load_cfg(16'h00F0, 16'h0F0F, 10, 12);
        push_vector(16'h1234);
        @(negedge clk_i);
        while (wwl_o == '0) begin
            @(negedge clk_i);
        end
        old_mode = 16'h0F0F;
        @(posedge clk_i);
        cfg_write_i <= 1'b1;
        cfg_addr_i  <= CFG_SPIN_MODE;
        cfg_wdata_i <= ~old_mode;
        @(posedge clk_i);
        cfg_write_i <= 1'b0;
        @(negedge clk_i);
        if (cfg_err_o !== 1'b1) begin
            flag_error("cfg_err_o not pulsed on a busy write");
        end
        if (cfg_rdata_o !== old_mode) begin
            flag_error($sformatf("busy write changed mode to %h", cfg_rdata_o));
        end
        @(negedge clk_i);
        if (cfg_err_o !== 1'b0) begin
            flag_error("cfg_err_o longer than one cycle");
        end
        while (!cmpt_finish_o) begin
            @(negedge clk_i);
        end

        // Fill the buffer with the RX disabled and then resume
        load_cfg(16'h8001, 16'h00FF, 2, 3);
        @(posedge clk_i);
        en_i <= 1'b0;
        for (i = 0; i < 5; i++) begin
            @(posedge clk_i);
            push_i      <= 1'b1;
            push_spin_i <= burst[i];
        end
        @(posedge clk_i);
        push_i <= 1'b0;
        repeat (5) begin
            @(negedge clk_i);
            if (full_o !== 1'b1) begin
                flag_error("full_o low after four pushes");
            end
            if (wbl_o !== '0 || wwl_o !== '0 || compute_en_o !== '0 || cmpt_finish_o) begin
                flag_error("macro outputs not zero with en_i low");
            end
        end
        @(posedge clk_i);
        en_i <= 1'b1;
        have_prev = 1'b0;
        idle_seen = 1'b0;
        for (i = 0; i < 4; i++) begin
            check_vector(burst[i], 16'h8001, 16'h00FF, 2, 3);
        end
        repeat (20) begin
            @(negedge clk_i);
            if (wwl_o !== '0 || full_o !== 1'b0) begin
                flag_error("dropped fifth vector was consumed");
            end
        end

        $display("Summary: %0d value errors, %0d assertion failures", errors,
                 u_spin_rx_top.u_analog_rx.u_spin_rx_assertions.fail_count);
        if (errors == 0 && u_spin_rx_top.u_analog_rx.u_spin_rx_assertions.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: testbench/spin_rx_assertions.sv
`timescale 1ns/1ps
// Protocol checks on the analog RX outputs, bound into analog_rx
// Assumes cyc_cmpt >= cyc_write, as the RX timing requires

module spin_rx_assertions
    import spin_rx_pkg::*;
(
    input logic      clk_i,
    input logic      reset_i,
    input spin_vec_t wwl_o,
    input logic      rx_idle_o,
    input logic      cmpt_finish_o,
    input logic      pop_ready_o
);

    // Read by the testbench for its closing summary
    int unsigned fail_count = 0;

    a_wwl_only_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        (wwl_o != '0) |-> !rx_idle_o)
    else begin
        $error("word lines high while the RX reports idle");
        fail_count++;
    end

    a_finish_after_wwl: assert property (@(posedge clk_i) disable iff (reset_i)
        cmpt_finish_o |-> (wwl_o == '0))
    else begin
        $error("compute finish high while word lines are up");
        fail_count++;
    end

    a_ready_not_in_write: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(pop_ready_o) |-> (wwl_o == '0))
    else begin
        $error("pop ready rose while word lines are up");
        fail_count++;
    end

endmodule

// File: src/spin_rx_top.sv
`timescale 1ns/1ps
// Receive path of the spin accelerator, from digital pushes to analog macro lines
// BUF_DEPTH sets the spin buffer size and must be a power of two, at least 2

module spin_rx_top
    import spin_rx_pkg::*;
#(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      en_i,
    // Config port
    input  logic      cfg_write_i,
    input  cfg_addr_e cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    output cfg_data_t cfg_rdata_o,
    output logic      cfg_err_o,
    // Digital core side
    input  logic      push_i,
    input  spin_vec_t push_spin_i,
    output logic      full_o,
    // Analog macro side
    input  logic      macro_idle_i,
    output spin_vec_t wbl_o,
    output spin_vec_t wwl_o,
    output spin_vec_t compute_en_o,
    output logic      cmpt_finish_o,
    output logic      rx_idle_o
);

    logic      pop_valid;
    logic      pop_ready;
    spin_vec_t pop_spin;
    rx_cfg_t   rx_cfg;

    spin_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_spin_buffer (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .en_i        (en_i),
        .push_i      (push_i),
        .push_spin_i (push_spin_i),
        .full_o      (full_o),
        .pop_valid_o (pop_valid),
        .pop_ready_i (pop_ready),
        .pop_spin_o  (pop_spin),
        .level_o     ()
    );

    rx_config_regs u_rx_config_regs (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .cfg_write_i (cfg_write_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .rx_idle_i   (rx_idle_o),
        .cfg_rdata_o (cfg_rdata_o),
        .cfg_err_o   (cfg_err_o),
        .cfg_o       (rx_cfg)
    );

    analog_rx u_analog_rx (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .en_i          (en_i),
        .cfg_i         (rx_cfg),
        .pop_valid_i   (pop_valid),
        .pop_spin_i    (pop_spin),
        .pop_ready_o   (pop_ready),
        .macro_idle_i  (macro_idle_i),
        .wbl_o         (wbl_o),
        .wwl_o         (wwl_o),
        .compute_en_o  (compute_en_o),
        .rx_idle_o     (rx_idle_o),
        .cmpt_finish_o (cmpt_finish_o)
    );

endmodule

// File: src/analog_rx.sv
`timescale 1ns/1ps
// Pops one spin vector per handshake and sequences the analog macro lines
// Both counts are timed from the handshake, keep cyc_cmpt >= cyc_write so that
// finish never rises while the word lines are still high
// en_i low drops the vector in flight and zeroes the macro outputs

module analog_rx
    import spin_rx_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      en_i,
    input  rx_cfg_t   cfg_i,
    // Handshake with the spin buffer
    input  logic      pop_valid_i,
    input  spin_vec_t pop_spin_i,
    output logic      pop_ready_o,
    // Analog macro side
    input  logic      macro_idle_i,
    output spin_vec_t wbl_o,
    output spin_vec_t wwl_o,
    output spin_vec_t compute_en_o,
    output logic      rx_idle_o,
    output logic      cmpt_finish_o
);

    rx_state_e state_q;
    rx_state_e state_d;
    logic      pop_cond;
    logic      wwl_maxed;
    logic      cmpt_maxed;
    logic      cmpt_busy_q;
    logic      settle_q;
    logic      cmpt_step;

    assign pop_cond  = en_i & pop_valid_i & pop_ready_o;
    // Compute timing skips the first cycle after the handshake
    assign cmpt_step = cmpt_busy_q & ~settle_q;
    // Busy only while the word lines are up
    assign rx_idle_o = (state_q != RX_WRITE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RX_IDLE: begin
                if (pop_cond) begin
                    state_d = RX_WRITE;
                end
            end
            RX_WRITE: begin
                if (wwl_maxed) begin
                    // Compute may already be done for short compute counts
                    state_d = (cmpt_busy_q && !cmpt_maxed) ? RX_CMPT : RX_IDLE;
                end
            end
            RX_CMPT: begin
                if (cmpt_maxed) begin
                    state_d = RX_IDLE;
                end
            end
            default: state_d = RX_IDLE;
        endcase
        if (!en_i) begin
            state_d = RX_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= RX_IDLE;
            cmpt_busy_q <= 1'b0;
            settle_q    <= 1'b0;
        end else begin
            state_q  <= state_d;
            settle_q <= pop_cond;
            if (!en_i || cmpt_maxed) begin
                cmpt_busy_q <= 1'b0;
            end else if (pop_cond) begin
                cmpt_busy_q <= 1'b1;
            end
        end
    end

    // Back-pressure, ready comes back only when idle and the macro says so
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pop_ready_o <= 1'b1;
        end else if (!en_i || pop_cond) begin
            pop_ready_o <= 1'b0;
        end else if (macro_idle_i && state_q == RX_IDLE) begin
            pop_ready_o <= 1'b1;
        end
    end

    // Bit lines hold the vector until the next handshake
    always_ff @(posedge clk_i) begin
        if (!en_i) begin
            wbl_o <= '0;
        end else if (pop_cond) begin
            wbl_o <= pop_spin_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || !en_i) begin
            wwl_o        <= '0;
            compute_en_o <= '0;
        end else if (pop_cond) begin
            wwl_o        <= cfg_i.wwl_strobe;
            compute_en_o <= cfg_i.spin_mode;
        end else if (wwl_maxed) begin
            wwl_o        <= '0;
            compute_en_o <= '0;
        end
    end

    // Finish is a level, cleared by the next handshake
    always_ff @(posedge clk_i) begin
        if (reset_i || !en_i) begin
            cmpt_finish_o <= 1'b0;
        end else if (pop_cond) begin
            cmpt_finish_o <= 1'b0;
        end else if (cmpt_maxed) begin
            cmpt_finish_o <= 1'b1;
        end
    end

    step_counter u_wwl_counter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .en_i    (en_i),
        .clear_i (pop_cond),
        .step_i  (state_q == RX_WRITE),
        .limit_i (cfg_i.cyc_write),
        .maxed_o (wwl_maxed)
    );

    step_counter u_cmpt_counter (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .en_i    (en_i),
        .clear_i (pop_cond),
        .step_i  (cmpt_step),
        .limit_i (cfg_i.cyc_cmpt),
        .maxed_o (cmpt_maxed)
    );

endmodule

// File: src/spin_buffer.sv
`timescale 1ns/1ps
// Circular FIFO of spin vectors between the digital core and the analog RX
// BUF_DEPTH must be a power of two and at least 2
// A push while full is ignored
// Pushes are taken regardless of en_i, pops only while en_i is high

module spin_buffer
    import spin_rx_pkg::*;
#(
    parameter int unsigned BUF_DEPTH = 4
) (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         en_i,
    input  logic                         push_i,
    input  spin_vec_t                    push_spin_i,
    output logic                         full_o,
    output logic                         pop_valid_o,
    input  logic                         pop_ready_i,
    output spin_vec_t                    pop_spin_o,
    output logic [$clog2(BUF_DEPTH):0]   level_o
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);

    spin_vec_t        mem_q [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   level_q;
    logic             push_ok;
    logic             pop_ok;

    assign full_o      = (level_q == (PTR_W + 1)'(BUF_DEPTH));
    assign pop_valid_o = (level_q != '0);
    assign pop_spin_o  = mem_q[rd_ptr_q];
    assign level_o     = level_q;

    assign push_ok = push_i & ~full_o;
    assign pop_ok  = en_i & pop_valid_o & pop_ready_i;

    // Vector storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_spin_i;
        end
    end

    // Pointers wrap on their own with a power of two depth
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            level_q <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

endmodule

// File: src/rx_config_regs.sv
`timescale 1ns/1ps
// Config registers for the analog RX, written by a plain strobe plus address
// Writes are dropped while the RX holds its word lines, cfg_err_o flags them a cycle later
// Readback is combinational on cfg_addr_i

module rx_config_regs
    import spin_rx_pkg::*;
(
    input  logic      clk_i,
    input  logic      reset_i,
    input  logic      cfg_write_i,
    input  cfg_addr_e cfg_addr_i,
    input  cfg_data_t cfg_wdata_i,
    input  logic      rx_idle_i,
    output cfg_data_t cfg_rdata_o,
    output logic      cfg_err_o,
    output rx_cfg_t   cfg_o
);

    rx_cfg_t cfg_q;
    logic    write_ok;
    logic    write_blocked;

    assign write_ok      = cfg_write_i & rx_idle_i;
    assign write_blocked = cfg_write_i & ~rx_idle_i;
    assign cfg_o         = cfg_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_q.wwl_strobe <= '0;
            cfg_q.spin_mode  <= '0;
            // Both counts must stay nonzero for the RX timing
            cfg_q.cyc_write  <= cycle_cnt_t'(1);
            cfg_q.cyc_cmpt   <= cycle_cnt_t'(1);
        end else if (write_ok) begin
            case (cfg_addr_i)
                CFG_WWL_STROBE: cfg_q.wwl_strobe <= cfg_wdata_i;
                CFG_SPIN_MODE:  cfg_q.spin_mode  <= cfg_wdata_i;
                CFG_CYC_WRITE:  cfg_q.cyc_write  <= cfg_wdata_i[CNT_W-1:0];
                CFG_CYC_CMPT:   cfg_q.cyc_cmpt   <= cfg_wdata_i[CNT_W-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cfg_err_o <= 1'b0;
        end else begin
            cfg_err_o <= write_blocked;
        end
    end

    // Readback, cycle fields zero extended to a full word
    always_comb begin
        case (cfg_addr_i)
            CFG_WWL_STROBE: cfg_rdata_o = cfg_q.wwl_strobe;
            CFG_SPIN_MODE:  cfg_rdata_o = cfg_q.spin_mode;
            CFG_CYC_WRITE:  cfg_rdata_o = cfg_data_t'(cfg_q.cyc_write);
            CFG_CYC_CMPT:   cfg_rdata_o = cfg_data_t'(cfg_q.cyc_cmpt);
            default:        cfg_rdata_o = '0;
        endcase
    end

endmodule

// File: src/step_counter.sv
`timescale 1ns/1ps
// Cycle counter compared directly against a limit
// maxed_o pulses on the step that takes the count to limit_i, then the count holds
// limit_i is expected to be at least 1

module step_counter
    import spin_rx_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,
    input  logic       en_i,
    input  logic       clear_i,
    input  logic       step_i,
    input  cycle_cnt_t limit_i,
    output logic       maxed_o
);

    cycle_cnt_t count_q;
    cycle_cnt_t count_d;
    logic       stepping;
    logic       at_limit;

    assign count_d  = count_q + cycle_cnt_t'(1);
    assign stepping = en_i & step_i;
    assign at_limit = (count_q == limit_i);

    // Single pulse, the count no longer moves once at the limit
    assign maxed_o = stepping & ~at_limit & (count_d == limit_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;
        end else if (stepping && !at_limit) begin
            count_q <= count_d;
        end
    end

endmodule

// File: src/spin_rx_pkg.sv
// Shared widths, types and encodings for the spin receive path
// Spin count and counter width are fixed for the whole design
// The buffer depth is the only module parameter

package spin_rx_pkg;

    localparam int unsigned NUM_SPIN   = 16;
    localparam int unsigned CNT_W      = 8;
    localparam int unsigned CFG_DATA_W = 16;

    // One bit per spin for data, masks and macro lines
    typedef logic [NUM_SPIN-1:0]   spin_vec_t;
    typedef logic [CNT_W-1:0]      cycle_cnt_t;
    typedef logic [CFG_DATA_W-1:0] cfg_data_t;

    // Config register map
    typedef enum logic [1:0] {
        CFG_WWL_STROBE = 2'd0,
        CFG_SPIN_MODE  = 2'd1,
        CFG_CYC_WRITE  = 2'd2,  // low CNT_W bits only
        CFG_CYC_CMPT   = 2'd3   // low CNT_W bits only
    } cfg_addr_e;

    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_WRITE = 2'd1,
        // Word lines are down but compute is still timing
        RX_CMPT  = 2'd2
    } rx_state_e;

    typedef struct packed {
        spin_vec_t  wwl_strobe;
        spin_vec_t  spin_mode;
        cycle_cnt_t cyc_write;
        cycle_cnt_t cyc_cmpt;
    } rx_cfg_t;

endpackage
